// ==== pkt_mon_pkg.sv ====
/* Packet monitor shared definitions */

`default_nettype none

package pkt_mon_pkg;

    //////////////////////////////////////////////////////////////////////
    // Stream and packet sizes
    localparam int data_bytes = 4;
    localparam int data_width = data_bytes * 8;
    localparam int max_words = 16;
    localparam int blen_width = $clog2(max_words * data_bytes + 1);
    localparam int word_idx_width = $clog2(max_words);

    //////////////////////////////////////////////////////////////////////
    // Expectation table layout
    localparam int num_ids = 2;
    localparam int slots_per_id = 4;
    localparam int num_slots = num_ids * slots_per_id;
    // Header word first, then the data words
    localparam int slot_words = max_words + 1;
    localparam int mem_depth = num_slots * slot_words;
    localparam int mem_addr_width = $clog2(mem_depth);
    localparam int slot_width = $clog2(num_slots);
    localparam int slot_sel_width = $clog2(slots_per_id);
    localparam int id_width = 1;

    //////////////////////////////////////////////////////////////////////
    // States and result codes
    typedef enum logic {
        ACCEPT,
        HOLD
    } asm_state_e;

    typedef enum logic [2:0] {
        IDLE,
        READ_LEN,
        CMP_WORD,
        NEXT_SLOT,
        REPORT
    } cmp_state_e;

    typedef enum logic [1:0] {
        RES_NONE,
        RES_MATCH,
        RES_MISS
    } result_e;

endpackage

`default_nettype wire

// ==== pkt_assembler.sv ====
/* Stream packet assembler */

`timescale 1ns/1ps
`default_nettype none

module pkt_assembler (
    input  logic                                   axis_packet_in_monitor,
    input  logic                                   rst_n,
    input  logic                                   tvalid,
    output logic                                   tready,
    input  logic [pkt_mon_pkg::data_width-1:0]     tdata,
    input  logic [pkt_mon_pkg::data_bytes-1:0]     tkeep,
    input  logic                                   tlast,
    input  logic [pkt_mon_pkg::id_width-1:0]       pkt_id,
    output logic                                   pkt_done,
    output logic [pkt_mon_pkg::blen_width-1:0]     rx_blen,
    output logic [pkt_mon_pkg::id_width-1:0]       rx_id,
    input  logic [pkt_mon_pkg::word_idx_width-1:0] rd_index,
    output logic [pkt_mon_pkg::data_width-1:0]     rd_word,
    input  logic                                   cmp_done
);
    import pkt_mon_pkg::*;

    // Number of valid bytes in a beat
    function automatic logic [blen_width-1:0] keep_count(input logic [data_bytes-1:0] keep);
        logic [blen_width-1:0] n;
        n = '0;
        for (int i = 0; i < data_bytes; i++) begin
            n = n + blen_width'(keep[i]);
        end
        return n;
    endfunction

    asm_state_e                state;
    logic [word_idx_width-1:0] wcnt;
    logic [data_width-1:0]     capture_buf [max_words];
    logic                      beat;

    assign tready = (state == ACCEPT);
    assign beat = tvalid && tready;

    // Comparator reads the captured words directly
    assign rd_word = capture_buf[rd_index];

    //////////////////////////////////////////////////////////////////////
    // Word counter and hold FSM
    always_ff @(posedge axis_packet_in_monitor or negedge rst_n) begin
        if (!rst_n) begin
            state <= ACCEPT;
            wcnt <= '0;
            pkt_done <= 1'b0;
        end else begin
            pkt_done <= 1'b0;
            case (state)
                ACCEPT: begin
                    if (beat) begin
                        if (tlast) begin
                            wcnt <= '0;
                            pkt_done <= 1'b1;
                            state <= HOLD;
                        end else begin
                            wcnt <= wcnt + 1'b1;
                        end
                    end
                end
                HOLD: begin
                    // Stream stays stalled until the search ends
                    if (cmp_done) begin
                        state <= ACCEPT;
                    end
                end
                default: state <= ACCEPT;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Capture buffer and packet info
    always_ff @(posedge axis_packet_in_monitor) begin
        if (beat) begin
            capture_buf[wcnt] <= tdata;
            if (tlast) begin
                rx_blen <= blen_width'(wcnt) * blen_width'(data_bytes) + keep_count(tkeep);
                rx_id <= pkt_id;
            end
        end
    end

endmodule

`default_nettype wire

// ==== expect_loader.sv ====
/* Expectation table loader */

`timescale 1ns/1ps
`default_nettype none

module expect_loader (
    input  logic                                   axis_packet_in_monitor,
    input  logic                                   rst_n,
    input  logic                                   host_wr,
    input  logic [pkt_mon_pkg::mem_addr_width-1:0] host_addr,
    input  logic [pkt_mon_pkg::data_width-1:0]     host_data,
    output logic                                   load_busy,
    output logic                                   req,
    input  logic                                   gnt,
    output logic [pkt_mon_pkg::mem_addr_width-1:0] wr_addr,
    output logic [pkt_mon_pkg::data_width-1:0]     wr_data,
    output logic                                   slot_loaded,
    output logic [pkt_mon_pkg::slot_width-1:0]     loaded_slot
);
    import pkt_mon_pkg::*;

    logic is_header;

    assign load_busy = req;
    // Word zero of each slot is the length header
    assign is_header = (mem_addr_width'(wr_addr % slot_words) == '0);

    always_ff @(posedge axis_packet_in_monitor or negedge rst_n) begin
        if (!rst_n) begin
            req <= 1'b0;
            slot_loaded <= 1'b0;
            loaded_slot <= '0;
        end else begin
            slot_loaded <= 1'b0;
            if (gnt) begin
                req <= 1'b0;
                if (is_header) begin
                    slot_loaded <= 1'b1;
                    loaded_slot <= slot_width'(wr_addr / slot_words);
                end
            end else if (host_wr && !req) begin
                req <= 1'b1;
            end
        end
    end

    // Pending write
    always_ff @(posedge axis_packet_in_monitor) begin
        if (host_wr && !req) begin
            wr_addr <= host_addr;
            wr_data <= host_data;
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
/* Expectation memory arbiter */

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                                   axis_packet_in_monitor,
    input  logic                                   rst_n,
    input  logic                                   ld_req,
    input  logic [pkt_mon_pkg::mem_addr_width-1:0] ld_addr,
    input  logic [pkt_mon_pkg::data_width-1:0]     ld_data,
    output logic                                   ld_gnt,
    input  logic                                   cmp_req,
    input  logic [pkt_mon_pkg::mem_addr_width-1:0] cmp_addr,
    output logic                                   cmp_gnt,
    output logic                                   mem_en,
    output logic                                   mem_we,
    output logic [pkt_mon_pkg::mem_addr_width-1:0] mem_addr,
    output logic [pkt_mon_pkg::data_width-1:0]     mem_wdata
);

    logic ld_sel;
    logic cmp_sel;

    // A requester that holds a grant is served, so it is masked for that cycle
    assign ld_sel = ld_req && !ld_gnt;
    assign cmp_sel = cmp_req && !cmp_gnt && !ld_sel;

    assign mem_en = ld_sel || cmp_sel;
    assign mem_we = ld_sel;
    assign mem_addr = ld_sel ? ld_addr : cmp_addr;
    assign mem_wdata = ld_data;

    // Grant follows the access by one cycle, with the read data
    always_ff @(posedge axis_packet_in_monitor or negedge rst_n) begin
        if (!rst_n) begin
            ld_gnt <= 1'b0;
            cmp_gnt <= 1'b0;
        end else begin
            ld_gnt <= ld_sel;
            cmp_gnt <= cmp_sel;
        end
    end

endmodule

`default_nettype wire

// ==== expect_mem.sv ====
/* Expectation memory */

`timescale 1ns/1ps
`default_nettype none

module expect_mem (
    input  logic                                   axis_packet_in_monitor,
    input  logic                                   mem_en,
    input  logic                                   mem_we,
    input  logic [pkt_mon_pkg::mem_addr_width-1:0] mem_addr,
    input  logic [pkt_mon_pkg::data_width-1:0]     mem_wdata,
    output logic [pkt_mon_pkg::data_width-1:0]     mem_rdata
);
    import pkt_mon_pkg::*;

    logic [data_width-1:0] ram [mem_depth];

    // Single port, read data one cycle later
    always_ff @(posedge axis_packet_in_monitor) begin
        if (mem_en) begin
            if (mem_we) begin
                ram[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= ram[mem_addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== pkt_comparator.sv ====
/* Received packet comparator */

`timescale 1ns/1ps
`default_nettype none

module pkt_comparator (
    input  logic                                   axis_packet_in_monitor,
    input  logic                                   rst_n,
    input  logic                                   pkt_done,
    input  logic [pkt_mon_pkg::blen_width-1:0]     rx_blen,
    input  logic [pkt_mon_pkg::id_width-1:0]       rx_id,
    output logic [pkt_mon_pkg::word_idx_width-1:0] rd_index,
    input  logic [pkt_mon_pkg::data_width-1:0]     rd_word,
    output logic                                   req,
    output logic [pkt_mon_pkg::mem_addr_width-1:0] rd_addr,
    input  logic                                   gnt,
    input  logic [pkt_mon_pkg::data_width-1:0]     mem_rdata,
    input  logic                                   slot_loaded,
    input  logic [pkt_mon_pkg::slot_width-1:0]     loaded_slot,
    output logic                                   cmp_done,
    output logic                                   result_valid,
    output pkt_mon_pkg::result_e                   result,
    output logic [pkt_mon_pkg::slot_width-1:0]     match_slot,
    output logic [pkt_mon_pkg::blen_width-1:0]     rpt_blen
);
    import pkt_mon_pkg::*;

    // Bytes of word idx that lie inside the packet
    function automatic logic [data_width-1:0] byte_mask(
        input logic [word_idx_width-1:0] idx,
        input logic [blen_width-1:0]     blen
    );
        logic [data_width-1:0] m;
        for (int b = 0; b < data_bytes; b++) begin
            m[b*8 +: 8] = (int'(idx) * data_bytes + b < int'(blen)) ? 8'hff : 8'h00;
        end
        return m;
    endfunction

    cmp_state_e                  state;
    logic [slot_sel_width:0]     slot_cnt;
    logic [word_idx_width-1:0]   word_idx;
    logic                        hit;
    logic [num_slots-1:0]        loaded;
    logic [num_slots-1:0]        received;
    logic [slot_width-1:0]       cur_slot;
    logic [mem_addr_width-1:0]   slot_base;
    logic [word_idx_width-1:0]   last_word;
    logic                        eligible;
    logic                        word_eq;

    assign cur_slot = slot_width'(rx_id * slots_per_id + slot_cnt[slot_sel_width-1:0]);
    assign slot_base = mem_addr_width'(cur_slot * slot_words);
    assign last_word = word_idx_width'((rx_blen - 1'b1) / data_bytes);
    assign eligible = loaded[cur_slot] && !received[cur_slot];
    assign word_eq = (((mem_rdata ^ rd_word) & byte_mask(word_idx, rx_blen)) == '0);
    assign rd_index = word_idx;

    //////////////////////////////////////////////////////////////////////
    // Search FSM
    always_ff @(posedge axis_packet_in_monitor or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            slot_cnt <= '0;
            word_idx <= '0;
            hit <= 1'b0;
            req <= 1'b0;
            rd_addr <= '0;
            loaded <= '0;
            received <= '0;
            cmp_done <= 1'b0;
            result_valid <= 1'b0;
            result <= RES_NONE;
            match_slot <= '0;
            rpt_blen <= '0;
        end else begin
            cmp_done <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pkt_done) begin
                        slot_cnt <= '0;
                        hit <= 1'b0;
                        state <= NEXT_SLOT;
                    end
                end
                NEXT_SLOT: begin
                    if (slot_cnt == (slot_sel_width+1)'(slots_per_id)) begin
                        state <= REPORT;
                    end else if (eligible) begin
                        rd_addr <= slot_base;
                        req <= 1'b1;
                        state <= READ_LEN;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                READ_LEN: begin
                    if (gnt) begin
                        if (mem_rdata[blen_width-1:0] == rx_blen) begin
                            word_idx <= '0;
                            rd_addr <= rd_addr + 1'b1;
                            state <= CMP_WORD;
                        end else begin
                            req <= 1'b0;
                            slot_cnt <= slot_cnt + 1'b1;
                            state <= NEXT_SLOT;
                        end
                    end
                end
                CMP_WORD: begin
                    if (gnt) begin
                        if (!word_eq) begin
                            req <= 1'b0;
                            slot_cnt <= slot_cnt + 1'b1;
                            state <= NEXT_SLOT;
                        end else if (word_idx == last_word) begin
                            req <= 1'b0;
                            hit <= 1'b1;
                            state <= REPORT;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                REPORT: begin
                    cmp_done <= 1'b1;
                    result_valid <= 1'b1;
                    result <= hit ? RES_MATCH : RES_MISS;
                    match_slot <= hit ? cur_slot : '0;
                    rpt_blen <= rx_blen;
                    if (hit) begin
                        received[cur_slot] <= 1'b1;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase

            // New header rearms the slot
            if (slot_loaded) begin
                loaded[loaded_slot] <= 1'b1;
                received[loaded_slot] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== axis_pkt_monitor_top.sv ====
/* AXI-stream packet monitor */

`timescale 1ns/1ps
`default_nettype none

module axis_pkt_monitor_top (
    input  logic                                   axis_packet_in_monitor,
    input  logic                                   rst_n,
    input  logic                                   tvalid,
    output logic                                   tready,
    input  logic [pkt_mon_pkg::data_width-1:0]     tdata,
    input  logic [pkt_mon_pkg::data_bytes-1:0]     tkeep,
    input  logic                                   tlast,
    input  logic [pkt_mon_pkg::id_width-1:0]       pkt_id,
    input  logic                                   host_wr,
    input  logic [pkt_mon_pkg::mem_addr_width-1:0] host_addr,
    input  logic [pkt_mon_pkg::data_width-1:0]     host_data,
    output logic                                   load_busy,
    output logic                                   result_valid,
    output pkt_mon_pkg::result_e                   result,
    output logic [pkt_mon_pkg::slot_width-1:0]     match_slot,
    output logic [pkt_mon_pkg::blen_width-1:0]     rpt_blen
);
    import pkt_mon_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Assembler to comparator
    logic                      pkt_done;
    logic                      cmp_done;
    logic [blen_width-1:0]     rx_blen;
    logic [id_width-1:0]       rx_id;
    logic [word_idx_width-1:0] rd_index;
    logic [data_width-1:0]     rd_word;

    //////////////////////////////////////////////////////////////////////
    // Memory side
    logic                      ld_req;
    logic                      ld_gnt;
    logic [mem_addr_width-1:0] ld_addr;
    logic [data_width-1:0]     ld_data;
    logic                      cmp_req;
    logic                      cmp_gnt;
    logic [mem_addr_width-1:0] cmp_addr;
    logic                      mem_en;
    logic                      mem_we;
    logic [mem_addr_width-1:0] mem_addr;
    logic [data_width-1:0]     mem_wdata;
    logic [data_width-1:0]     mem_rdata;
    logic                      slot_loaded;
    logic [slot_width-1:0]     loaded_slot;

    pkt_assembler u_assembler (
        .axis_packet_in_monitor(axis_packet_in_monitor),
        .rst_n(rst_n),
        .tvalid(tvalid),
        .tready(tready),
        .tdata(tdata),
        .tkeep(tkeep),
        .tlast(tlast),
        .pkt_id(pkt_id),
        .pkt_done(pkt_done),
        .rx_blen(rx_blen),
        .rx_id(rx_id),
        .rd_index(rd_index),
        .rd_word(rd_word),
        .cmp_done(cmp_done)
    );

    expect_loader u_loader (
        .axis_packet_in_monitor(axis_packet_in_monitor),
        .rst_n(rst_n),
        .host_wr(host_wr),
        .host_addr(host_addr),
        .host_data(host_data),
        .load_busy(load_busy),
        .req(ld_req),
        .gnt(ld_gnt),
        .wr_addr(ld_addr),
        .wr_data(ld_data),
        .slot_loaded(slot_loaded),
        .loaded_slot(loaded_slot)
    );

    mem_arbiter u_arbiter (
        .axis_packet_in_monitor(axis_packet_in_monitor),
        .rst_n(rst_n),
        .ld_req(ld_req),
        .ld_addr(ld_addr),
        .ld_data(ld_data),
        .ld_gnt(ld_gnt),
        .cmp_req(cmp_req),
        .cmp_addr(cmp_addr),
        .cmp_gnt(cmp_gnt),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata)
    );

    expect_mem u_mem (
        .axis_packet_in_monitor(axis_packet_in_monitor),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    pkt_comparator u_comparator (
        .axis_packet_in_monitor(axis_packet_in_monitor),
        .rst_n(rst_n),
        .pkt_done(pkt_done),
        .rx_blen(rx_blen),
        .rx_id(rx_id),
        .rd_index(rd_index),
        .rd_word(rd_word),
        .req(cmp_req),
        .rd_addr(cmp_addr),
        .gnt(cmp_gnt),
        .mem_rdata(mem_rdata),
        .slot_loaded(slot_loaded),
        .loaded_slot(loaded_slot),
        .cmp_done(cmp_done),
        .result_valid(result_valid),
        .result(result),
        .match_slot(match_slot),
        .rpt_blen(rpt_blen)
    );

endmodule

`default_nettype wire

// ==== tb_axis_pkt_monitor.sv ====
/* Packet monitor testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_axis_pkt_monitor;
    import pkt_mon_pkg::*;

    localparam int num_tests = 6;
    localparam int clk_period = 100;
    localparam int timeout_cycles = 8 + num_tests * 200;

    logic                      axis_packet_in_monitor = 1'b0;
    logic                      rst_n;
    logic                      tvalid;
    logic                      tready;
    logic [data_width-1:0]     tdata;
    logic [data_bytes-1:0]     tkeep;
    logic                      tlast;
    logic [id_width-1:0]       pkt_id;
    logic                      host_wr;
    logic [mem_addr_width-1:0] host_addr;
    logic [data_width-1:0]     host_data;
    logic                      load_busy;
    logic                      result_valid;
    result_e                   result;
    logic [slot_width-1:0]     match_slot;
    logic [blen_width-1:0]     rpt_blen;

    // Model of the expectation table and its flags
    logic [data_width-1:0] exp_mem [num_slots][max_words];
    int                    exp_len [num_slots];
    bit                    mloaded [num_slots];
    bit                    mrecv [num_slots];

    // Packet on its way to the DUT
    logic [data_width-1:0] tx_words [max_words];
    int                    tx_len;
    int                    tx_id;

    int      exp_slot_q [$];
    int      exp_blen_q [$];
    int      exp_slot;
    int      exp_blen;
    result_e exp_res;
    integer  seed = 32'h33f5;
    int      errors = 0;
    int      checks = 0;
    int      tests_passed = 0;
    int      test_num = 0;
    int      errors_at_start = 0;
    logic    hold_chk = 1'b0;

    axis_pkt_monitor_top uut (
        .axis_packet_in_monitor(axis_packet_in_monitor),
        .rst_n(rst_n),
        .tvalid(tvalid),
        .tready(tready),
        .tdata(tdata),
        .tkeep(tkeep),
        .tlast(tlast),
        .pkt_id(pkt_id),
        .host_wr(host_wr),
        .host_addr(host_addr),
        .host_data(host_data),
        .load_busy(load_busy),
        .result_valid(result_valid),
        .result(result),
        .match_slot(match_slot),
        .rpt_blen(rpt_blen)
    );

    always #(clk_period / 2) axis_packet_in_monitor = ~axis_packet_in_monitor;

    //////////////////////////////////////////////////////////////////////
    // Reference search over the model, -1 means a miss
    function automatic int expected_slot();
        int  s;
        int  slot;
        int  b;
        bit  same;
        for (s = 0; s < slots_per_id; s++) begin
            slot = tx_id * slots_per_id + s;
            if (mloaded[slot] && !mrecv[slot] && exp_len[slot] == tx_len) begin
                same = 1'b1;
                for (b = 0; b < tx_len; b++) begin
                    if (exp_mem[slot][b / data_bytes][(b % data_bytes) * 8 +: 8] !=
                        tx_words[b / data_bytes][(b % data_bytes) * 8 +: 8]) begin
                        same = 1'b0;
                    end
                end
                if (same) begin
                    return slot;
                end
            end
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Host side
    task automatic host_write(input int addr, input logic [data_width-1:0] data);
        while (load_busy) begin
            @(negedge axis_packet_in_monitor);
        end
        host_wr = 1'b1;
        host_addr = mem_addr_width'(addr);
        host_data = data;
        @(negedge axis_packet_in_monitor);
        host_wr = 1'b0;
    endtask

    // Lets the last header reach the comparator flags
    task automatic wait_loader_idle();
        while (load_busy) begin
            @(negedge axis_packet_in_monitor);
        end
        repeat (2) @(negedge axis_packet_in_monitor);
    endtask

    // Data words first, header last
    task automatic load_slot(input int slot, input int len);
        int nwords;
        int w;
        nwords = (len + data_bytes - 1) / data_bytes;
        for (w = 0; w < nwords; w++) begin
            exp_mem[slot][w] = $random(seed);
            host_write(slot * slot_words + 1 + w, exp_mem[slot][w]);
        end
        host_write(slot * slot_words, data_width'(len));
        exp_len[slot] = len;
        mloaded[slot] = 1'b1;
        mrecv[slot] = 1'b0;
        wait_loader_idle();
    endtask

    task automatic reload_header(input int slot);
        host_write(slot * slot_words, data_width'(exp_len[slot]));
        mloaded[slot] = 1'b1;
        mrecv[slot] = 1'b0;
        wait_loader_idle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream side
    task automatic make_packet(input int slot);
        int w;
        tx_id = slot / slots_per_id;
        tx_len = exp_len[slot];
        for (w = 0; w < max_words; w++) begin
            tx_words[w] = exp_mem[slot][w];
        end
    endtask

    task automatic send_packet();
        int nwords;
        int slot;
        int w;
        int rem;
        int b;
        nwords = (tx_len + data_bytes - 1) / data_bytes;
        slot = expected_slot();
        exp_slot_q.push_back(slot);
        exp_blen_q.push_back(tx_len);
        if (slot >= 0) begin
            mrecv[slot] = 1'b1;
        end
        for (w = 0; w < nwords; w++) begin
            rem = tx_len - w * data_bytes;
            tvalid = 1'b1;
            tdata = tx_words[w];
            tlast = (w == nwords - 1);
            tkeep = (rem >= data_bytes) ? '1 : data_bytes'((1 << rem) - 1);
            // Bytes past tkeep carry junk
            for (b = rem; b < data_bytes; b++) begin
                tdata[b*8 +: 8] = ~tx_words[w][b*8 +: 8];
            end
            pkt_id = id_width'(tx_id);
            // Source holds the beat while the DUT is busy
            while (!tready) begin
                @(negedge axis_packet_in_monitor);
            end
            @(negedge axis_packet_in_monitor);
        end
        tvalid = 1'b0;
        tlast = 1'b0;
        hold_chk = 1'b1;
    endtask

    task automatic wait_results();
        while (exp_slot_q.size() != 0) begin
            @(posedge axis_packet_in_monitor);
        end
        @(negedge axis_packet_in_monitor);
    endtask

    task automatic end_test(input string name);
        wait_results();
        test_num++;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Result checking
    always @(negedge axis_packet_in_monitor) begin
        if (hold_chk && tready) begin
            errors++;
            $display("FAIL at %0t ns: tready expected 0 got 1", $time);
        end
        if (result_valid) begin
            hold_chk = 1'b0;
            if (exp_slot_q.size() == 0) begin
                errors++;
                $display("result_valid pulsed at %0t ns with no packet outstanding", $time);
            end else begin
                exp_slot = exp_slot_q.pop_front();
                exp_blen = exp_blen_q.pop_front();
                exp_res = (exp_slot >= 0) ? RES_MATCH : RES_MISS;
                checks++;
                if (result != exp_res) begin
                    errors++;
                    $display("FAIL at %0t ns: result expected %0d got %0d",
                             $time, exp_res, result);
                end
                if (exp_slot >= 0 && match_slot != slot_width'(exp_slot)) begin
                    errors++;
                    $display("FAIL at %0t ns: match_slot expected %0d got %0d",
                             $time, exp_slot, match_slot);
                end
                if (rpt_blen != blen_width'(exp_blen)) begin
                    errors++;
                    $display("FAIL at %0t ns: rpt_blen expected %0d got %0d",
                             $time, exp_blen, rpt_blen);
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles with results still outstanding",
                 timeout_cycles);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        rst_n = 1'b0;
        tvalid = 1'b0;
        tdata = '0;
        tkeep = '0;
        tlast = 1'b0;
        pkt_id = '0;
        host_wr = 1'b0;
        host_addr = '0;
        host_data = '0;
        repeat (8) @(negedge axis_packet_in_monitor);
        rst_n = 1'b1;
        @(negedge axis_packet_in_monitor);
        if (!tready || result_valid || load_busy) begin
            errors++;
            $display("outputs not at their idle values after reset");
        end

        load_slot(0, 4);
        make_packet(0);
        send_packet();
        end_test("single full word");

        load_slot(1, 19);
        make_packet(1);
        send_packet();
        end_test("partial last beat");

        // One byte flipped, then one byte short
        load_slot(2, 10);
        make_packet(2);
        tx_words[1][7:0] = ~tx_words[1][7:0];
        send_packet();
        make_packet(2);
        tx_len = 9;
        send_packet();
        end_test("byte and length mismatch");

        make_packet(0);
        send_packet();
        wait_results();
        reload_header(0);
        make_packet(0);
        send_packet();
        end_test("consumed slot and reload");

        load_slot(4, 8);
        make_packet(4);
        tx_id = 0;
        send_packet();
        end_test("payload under other id");

        // Second packet waits at the source while the host loads slot 5
        load_slot(3, 64);
        fork
            begin
                make_packet(3);
                send_packet();
                make_packet(2);
                send_packet();
            end
            begin
                // Host writes contend with the compare of the first packet
                while (tready) begin
                    @(negedge axis_packet_in_monitor);
                end
                load_slot(5, 12);
            end
        join
        make_packet(5);
        send_packet();
        end_test("back-pressure and host writes");

        repeat (4) @(negedge axis_packet_in_monitor);
        $display("summary: %0d of %0d tests passed, %0d results checked, %0d errors",
                 tests_passed, num_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
pkt_mon_pkg.sv
pkt_assembler.sv
expect_loader.sv
mem_arbiter.sv
expect_mem.sv
pkt_comparator.sv
axis_pkt_monitor_top.sv
tb_axis_pkt_monitor.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the packet monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axis_pkt_monitor -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_axis_pkt_monitor)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
